//--- Makefile
TOP = issue_buffer_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP)

run: build
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only --timing -Wall -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

//--- testbench/issue_buffer_chk.sv
// ------------------------------------------------
// Bound checks on the issue buffer
// Lane contiguity check written for ALU_NUM of 2
// ------------------------------------------------
`timescale 1ns/100ps

module issue_buffer_chk import ib_pkg::*; (
    input logic                   clk_i,
    input logic                   rst_i,
    input logic                   exception_i,
    input logic     [ALU_NUM-1:0] alu_ready_i,
    input logic    [IB_IDX_W-1:0] head_i,
    input logic    [IB_IDX_W-1:0] tail_i,
    input logic                   head_wrap_i,
    input logic                   tail_wrap_i,
    input logic     [ALU_NUM-1:0] res_valid_i,
    input logic     [ALU_NUM-1:0] res_ready_i,
    input alu_res_t [ALU_NUM-1:0] res_data_i
);

    logic [IB_CNT_W-1:0] stored;

    // Assertion failures so far
    int err_cnt = 0;

    // Occupancy from pointers and wrap bits
    assign stored = (head_wrap_i == tail_wrap_i) ?
                    ({1'b0, tail_i} - {1'b0, head_i}) :
                    (IB_CNT_W'(IB_DEPTH) - {1'b0, head_i} + {1'b0, tail_i});

    a_contig: assert property (@(posedge clk_i) disable iff (rst_i)
        !(alu_ready_i[1] && !alu_ready_i[0]))
        else begin
            $error("ALU readiness not contiguous");
            err_cnt++;
        end

    // Pointer with wrap bit counts modulo twice IB_DEPTH
    // and moves by at most one group of lanes per edge
    a_ptr: assert property (@(posedge clk_i) disable iff (rst_i)
        !exception_i |=>
            (IB_CNT_W'({head_wrap_i, head_i} - $past({head_wrap_i, head_i}))
                <= IB_CNT_W'(ALU_NUM)) &&
            (IB_CNT_W'({tail_wrap_i, tail_i} - $past({tail_wrap_i, tail_i}))
                <= IB_CNT_W'(IS_NUM)))
        else begin
            $error("queue pointer moved too far");
            err_cnt++;
        end

    a_stored: assert property (@(posedge clk_i) disable iff (rst_i)
        stored <= IB_CNT_W'(IB_DEPTH))
        else begin
            $error("queue holds more than IB_DEPTH entries");
            err_cnt++;
        end

    // Stalled result data must not move
    for (genvar k = 0; k < ALU_NUM; k++) begin : g_hold
        a_hold: assert property (@(posedge clk_i) disable iff (rst_i)
            (res_valid_i[k] && !res_ready_i[k]) |=> $stable(res_data_i[k]))
            else begin
                $error("stalled result changed");
                err_cnt++;
            end
    end

endmodule

bind issue_buffer issue_buffer_chk u_chk (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .exception_i (exception_i),
    .alu_ready_i (m_ready),
    .head_i      (u_queue.head_q),
    .tail_i      (u_queue.tail_q),
    .head_wrap_i (u_queue.head_wrap_q),
    .tail_wrap_i (u_queue.tail_wrap_q),
    .res_valid_i (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_data_i  (res_data_o)
);

//--- testbench/issue_buffer_tb.sv
// ------------------------------------------------
// Random test of the issue buffer against a tag model
// Lane 0 stalls only behind a held lane 1 result,
// so ALU readiness stays contiguous (ALU_NUM of 2)
// ------------------------------------------------
`timescale 1ns/100ps

module issue_buffer_tb import ib_pkg::*; ();

    localparam int RUN_CYC   = 640;
    localparam int STALL_BEG = 300;
    localparam int STALL_END = 360;
    localparam int DRAIN_BEG = 600;

    logic                   clk_i = 1'b0;
    logic                   rst_i;
    logic     [IS_NUM-1:0]  s_valid_i;
    logic     [IS_NUM-1:0]  s_ready_o;
    is_inst_t [IS_NUM-1:0]  s_data_i;
    br_mis_t                br_mis_i;
    logic                   exception_i;
    logic     [ALU_NUM-1:0] res_valid_o;
    logic     [ALU_NUM-1:0] res_ready_i;
    alu_res_t [ALU_NUM-1:0] res_data_o;

    // Expected results of in-flight work, by tag
    alu_res_t         exp_res [logic [TAG_W-1:0]];
    logic [TAG_W-1:0] next_tag;
    logic             exc_seen;

    always #4 clk_i = ~clk_i;

    issue_buffer uut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .s_valid_i   (s_valid_i),
        .s_ready_o   (s_ready_o),
        .s_data_i    (s_data_i),
        .br_mis_i    (br_mis_i),
        .exception_i (exception_i),
        .res_valid_o (res_valid_o),
        .res_ready_i (res_ready_i),
        .res_data_o  (res_data_o)
    );

    task automatic stop_run();
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_res(string name, alu_res_t exp, alu_res_t act);
        if (exp !== act) begin
            $display("error %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic compare_flag(string name, logic exp, logic act);
        if (exp !== act) begin
            $display("error %s expected %b actual %b", name, exp, act);
            stop_run();
        end
    endtask

    // Reference ALU, immediate taken from the low 12 bits
    function automatic alu_res_t model_result(is_inst_t inst);
        alu_res_t    r;
        logic [31:0] b;
        b = inst.use_imm ? {{20{inst.src_b.reg_val[11]}}, inst.src_b.reg_val[11:0]}
                         : inst.src_b.reg_val;
        r.thread_idx = inst.thread_idx;
        r.tag        = inst.tag;
        case (inst.op)
            ALU_ADD: r.value = inst.src_a + b;
            ALU_SUB: r.value = inst.src_a - b;
            ALU_AND: r.value = inst.src_a & b;
            ALU_OR:  r.value = inst.src_a | b;
            ALU_XOR: r.value = inst.src_a ^ b;
            ALU_SLL: r.value = inst.src_a << b[4:0];
            default: r.value = inst.src_a >> b[4:0];
        endcase
        return r;
    endfunction

    function automatic is_inst_t make_inst(logic [TAG_W-1:0] tag);
        is_inst_t inst;
        inst.live          = 1'b1;
        inst.thread_idx    = 1'($urandom_range(0, 1));
        inst.tag           = tag;
        inst.op            = alu_op_e'(3'($urandom_range(0, 6)));
        inst.use_imm       = 1'($urandom_range(0, 1));
        inst.src_a         = $urandom();
        inst.src_b.reg_val = $urandom();
        return inst;
    endfunction

    // ------------------------------------------------
    // Model update on values seen before the edge
    // ------------------------------------------------
    task automatic check_cycle(int cyc);
        logic [TAG_W-1:0] tag;
        logic [TAG_W-1:0] keys[$];
        if (uut.u_chk.err_cnt != 0) begin
            $display("a bound assertion on the queue or the ALU lanes failed");
            stop_run();
        end
        if (cyc == 0 || exc_seen) begin
            for (int i = 0; i < IS_NUM; i++) begin
                compare_flag("push ready idle", 1'b1, s_ready_o[i]);
            end
        end
        for (int k = 0; k < ALU_NUM; k++) begin
            if (cyc == 0) begin
                compare_flag("res_valid after reset", 1'b0, res_valid_o[k]);
            end
            if (res_valid_o[k] && res_ready_i[k]) begin
                tag = res_data_o[k].tag;
                if (!exp_res.exists(tag)) begin
                    $display("result for tag %0d that is not in flight", tag);
                    stop_run();
                end
                compare_res("result", exp_res[tag], res_data_o[k]);
                exp_res.delete(tag);
            end
        end
        for (int i = 0; i < IS_NUM; i++) begin
            if (s_valid_i[i] && s_ready_o[i]) begin
                exp_res[s_data_i[i].tag] = model_result(s_data_i[i]);
            end
        end
        // Squash hits work accepted up to and including this edge
        if (exception_i) begin
            exp_res.delete();
        end else if (br_mis_i.valid != '0) begin
            foreach (exp_res[t]) begin
                if (br_mis_i.valid[exp_res[t].thread_idx]) begin
                    keys.push_back(t);
                end
            end
            foreach (keys[j]) begin
                exp_res.delete(keys[j]);
            end
        end
        compare_flag("in flight bound", 1'b1, exp_res.num() <= IB_DEPTH + ALU_NUM);
        if (cyc == STALL_END) begin
            for (int i = 0; i < IS_NUM; i++) begin
                compare_flag("push ready when full", 1'b0, s_ready_o[i]);
            end
        end
        exc_seen = exception_i;
    endtask

    // ------------------------------------------------
    // Stimulus for the next cycle
    // ------------------------------------------------
    task automatic drive_cycle(int cyc);
        int                     n;
        logic                   stall_win;
        logic                   drain;
        logic [TAG_W-1:0]       tag;
        logic     [IS_NUM-1:0]  valid;
        is_inst_t [IS_NUM-1:0]  data;
        logic     [ALU_NUM-1:0] rdy;
        br_mis_t                mis;
        logic                   exc;
        stall_win = (cyc >= STALL_BEG) && (cyc < STALL_END);
        drain     = (cyc >= DRAIN_BEG);
        n = drain ? 0 : (stall_win ? IS_NUM : int'($urandom_range(0, IS_NUM)));
        tag = next_tag;
        for (int i = 0; i < IS_NUM; i++) begin
            while (exp_res.exists(tag)) begin
                tag++;
            end
            valid[i] = (i < n);
            data[i]  = make_inst(tag);
            tag++;
        end
        next_tag = tag;
        mis = '0;
        exc = 1'b0;
        if (!stall_win && !drain) begin
            if ($urandom_range(0, 99) < 3) begin
                mis.valid = THREAD_NUM'(1) << $urandom_range(0, THREAD_NUM - 1);
            end
            exc = ($urandom_range(0, 149) == 0);
        end
        rdy[1] = drain ? 1'b1 : (stall_win ? 1'b0 : 1'($urandom_range(0, 1)));
        rdy[0] = 1'b1;
        // Lane 1 result certain to stay held through the next cycle
        if (res_valid_o[1] && !res_ready_i[1] && !rdy[1] && br_mis_i.valid == '0 &&
            mis.valid == '0 && !exception_i && !exc) begin
            rdy[0] = stall_win ? 1'b0 : 1'($urandom_range(0, 1));
        end
        s_valid_i   <= valid;
        s_data_i    <= data;
        br_mis_i    <= mis;
        exception_i <= exc;
        res_ready_i <= rdy;
    endtask

    initial begin
        void'($urandom(32'h6eb0_5bff));
        rst_i       = 1'b1;
        s_valid_i   = '0;
        s_data_i    = '0;
        br_mis_i    = '0;
        exception_i = 1'b0;
        res_ready_i = '0;
        next_tag    = '0;
        exc_seen    = 1'b0;
        repeat (3) @(posedge clk_i);
        rst_i <= 1'b0;
        for (int cyc = 0; cyc < RUN_CYC; cyc++) begin
            @(posedge clk_i);
            check_cycle(cyc);
            drive_cycle(cyc);
        end
        compare_flag("all work drained", 1'b1, exp_res.num() == 0);
        if (uut.u_chk.err_cnt == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("a bound assertion on the queue or the ALU lanes failed");
            stop_run();
        end
    end

    // Watchdog, planned cycles plus margin
    initial begin
        #((RUN_CYC + 3) * 8 + 400);
        $display("timeout, the run did not finish in time");
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- verilog.f
verilog/ib_pkg.sv
verilog/ib_queue.sv
verilog/ib_alu_lane.sv
verilog/issue_buffer.sv
testbench/issue_buffer_chk.sv
testbench/issue_buffer_tb.sv

//--- verilog/ib_alu_lane.sv
// ------------------------------------------------
// Single-cycle ALU lane with one registered result
// Result held while res_ready_i is low
// ------------------------------------------------
`timescale 1ns/100ps

module ib_alu_lane import ib_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    // Instruction from the queue
    input  logic     inst_valid_i,
    output logic     inst_ready_o,
    input  is_inst_t inst_i,
    // Squash and flush
    input  br_mis_t  br_mis_i,
    input  logic     exception_i,
    // Result
    output logic     res_valid_o,
    input  logic     res_ready_i,
    output alu_res_t res_o
);

    logic        res_valid_q;
    alu_res_t    res_q;
    logic        accept;
    logic        in_kill;
    logic        held_kill;
    logic [31:0] opnd_b;
    logic [31:0] alu_out;

    // Free when empty or when the held result leaves now
    assign inst_ready_o = ~res_valid_q | res_ready_i;
    assign accept       = inst_valid_i & inst_ready_o;

    assign in_kill   = ~inst_i.live | br_mis_i.valid[inst_i.thread_idx];
    assign held_kill = br_mis_i.valid[res_q.thread_idx];

    // Second operand, register word or sign-extended immediate
    assign opnd_b = inst_i.use_imm ?
                    {{20{inst_i.src_b.imm.value[11]}}, inst_i.src_b.imm.value} :
                    inst_i.src_b.reg_val;

    always_comb begin
        case (inst_i.op)
            ALU_ADD: alu_out = inst_i.src_a + opnd_b;
            ALU_SUB: alu_out = inst_i.src_a - opnd_b;
            ALU_AND: alu_out = inst_i.src_a & opnd_b;
            ALU_OR:  alu_out = inst_i.src_a | opnd_b;
            ALU_XOR: alu_out = inst_i.src_a ^ opnd_b;
            // Shift amount from low 5 bits
            ALU_SLL: alu_out = inst_i.src_a << opnd_b[4:0];
            ALU_SRL: alu_out = inst_i.src_a >> opnd_b[4:0];
            default: alu_out = '0;
        endcase
    end

    // ------------------------------------------------
    // Result register
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || exception_i) begin
            res_valid_q <= 1'b0;
        end else if (accept) begin
            // Non-live or squashed work gives no result
            res_valid_q <= ~in_kill;
        end else if (res_valid_q && (res_ready_i || held_kill)) begin
            res_valid_q <= 1'b0;
        end
    end

    // Payload loads only on acceptance
    always_ff @(posedge clk_i) begin
        if (accept) begin
            res_q.thread_idx <= inst_i.thread_idx;
            res_q.tag        <= inst_i.tag;
            res_q.value      <= alu_out;
        end
    end

    assign res_valid_o = res_valid_q;
    assign res_o       = res_q;

endmodule

//--- verilog/ib_pkg.sv
// ------------------------------------------------
// Shared sizes and types of the integer issue path
// IB_DEPTH must be a power of two, IS_NUM and ALU_NUM
// no larger than IB_DEPTH
// ------------------------------------------------
package ib_pkg;

    // Sizes
    localparam int IB_DEPTH   = 8;
    localparam int IS_NUM     = 2;
    localparam int ALU_NUM    = 2;
    localparam int THREAD_NUM = 2;
    localparam int IB_IDX_W   = $clog2(IB_DEPTH);
    localparam int IB_CNT_W   = IB_IDX_W + 1;
    localparam int TAG_W      = 8;

    // ALU operations, 3-bit encoding
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    // Second operand word, register value or 12-bit immediate
    typedef union packed {
        logic [31:0] reg_val;
        struct packed {
            logic        [19:0] pad;
            logic signed [11:0] value;
        } imm;
    } alu_operand_u;

    // Instruction as held in the queue
    typedef struct packed {
        logic         live;
        logic         thread_idx;
        logic [TAG_W-1:0] tag;
        alu_op_e      op;
        logic         use_imm;
        logic [31:0]  src_a;
        alu_operand_u src_b;
    } is_inst_t;

    // One flag per mispredicting thread
    typedef struct packed {
        logic [THREAD_NUM-1:0] valid;
    } br_mis_t;

    // Finished result
    typedef struct packed {
        logic             thread_idx;
        logic [TAG_W-1:0] tag;
        logic [31:0]      value;
    } alu_res_t;

endpackage

//--- verilog/ib_queue.sv
// ------------------------------------------------
// Circular issue queue, IS_NUM pushes and ALU_NUM pops per cycle
// Push lanes must be valid from lane 0 up, pop readiness contiguous
// Squashed entries keep their slot with live cleared
// ------------------------------------------------
`timescale 1ns/100ps

module ib_queue import ib_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_i,
    // Push side
    input  logic     [IS_NUM-1:0]    s_valid_i,
    output logic     [IS_NUM-1:0]    s_ready_o,
    input  is_inst_t [IS_NUM-1:0]    s_data_i,
    // Pop side
    output logic     [ALU_NUM-1:0]   m_valid_o,
    input  logic     [ALU_NUM-1:0]   m_ready_i,
    output is_inst_t [ALU_NUM-1:0]   m_data_o,
    // Squash and flush
    input  br_mis_t                  br_mis_i,
    input  logic                     exception_i
);

    // Pointers with wrap bits
    logic [IB_IDX_W-1:0] head_q;
    logic [IB_IDX_W-1:0] tail_q;
    logic                head_wrap_q;
    logic                tail_wrap_q;

    // Pointer sums before the modulo step
    logic [IB_CNT_W-1:0] head_sum;
    logic [IB_CNT_W-1:0] tail_sum;

    // Per-cycle counts
    logic [IB_CNT_W-1:0] push_cnt;
    logic [IB_CNT_W-1:0] pop_cnt;
    logic [IB_CNT_W-1:0] stored_cnt;
    logic [IB_CNT_W-1:0] free_cnt;

    logic [IS_NUM-1:0]   push_en;
    logic [ALU_NUM-1:0]  pop_en;

    logic [IS_NUM-1:0][IB_IDX_W-1:0]  push_idx;
    logic [ALU_NUM-1:0][IB_IDX_W-1:0] pop_idx;

    // Entry storage and write steering
    is_inst_t            entry_q [IB_DEPTH];
    is_inst_t            wr_data [IB_DEPTH];
    logic [IB_DEPTH-1:0] wr_en;

    // Index a fixed offset past a pointer, modulo IB_DEPTH
    function automatic logic [IB_IDX_W-1:0] wrap_add(
        input logic [IB_IDX_W-1:0] ptr,
        input int                  off
    );
        logic [IB_CNT_W-1:0] sum;
        sum = {1'b0, ptr} + IB_CNT_W'(off);
        if (sum >= IB_CNT_W'(IB_DEPTH)) begin
            sum = sum - IB_CNT_W'(IB_DEPTH);
        end
        return IB_IDX_W'(sum);
    endfunction

    // ------------------------------------------------
    // Handshakes and counts
    // ------------------------------------------------
    assign push_en = s_valid_i & s_ready_o;
    assign pop_en  = m_valid_o & m_ready_i;

    always_comb begin
        push_cnt = '0;
        for (int i = 0; i < IS_NUM; i++) begin
            push_cnt = push_cnt + IB_CNT_W'(push_en[i]);
        end
        pop_cnt = '0;
        for (int k = 0; k < ALU_NUM; k++) begin
            pop_cnt = pop_cnt + IB_CNT_W'(pop_en[k]);
        end
    end

    // Stored entries from pointers and wrap bits
    always_comb begin
        if (head_wrap_q == tail_wrap_q) begin
            stored_cnt = {1'b0, tail_q} - {1'b0, head_q};
        end else begin
            stored_cnt = IB_CNT_W'(IB_DEPTH) - {1'b0, head_q} + {1'b0, tail_q};
        end
    end

    // Slots popped this cycle count as free
    assign free_cnt = IB_CNT_W'(IB_DEPTH) - stored_cnt + pop_cnt;

    // ------------------------------------------------
    // Pointer update
    // ------------------------------------------------
    assign head_sum = {1'b0, head_q} + pop_cnt;
    assign tail_sum = {1'b0, tail_q} + push_cnt;

    always_ff @(posedge clk_i) begin
        if (rst_i || exception_i) begin
            head_q      <= '0;
            tail_q      <= '0;
            head_wrap_q <= 1'b0;
            tail_wrap_q <= 1'b0;
        end else begin
            // Wrap past the last entry flips the wrap bit
            if (head_sum >= IB_CNT_W'(IB_DEPTH)) begin
                head_q      <= IB_IDX_W'(head_sum - IB_CNT_W'(IB_DEPTH));
                head_wrap_q <= ~head_wrap_q;
            end else begin
                head_q <= IB_IDX_W'(head_sum);
            end
            if (tail_sum >= IB_CNT_W'(IB_DEPTH)) begin
                tail_q      <= IB_IDX_W'(tail_sum - IB_CNT_W'(IB_DEPTH));
                tail_wrap_q <= ~tail_wrap_q;
            end else begin
                tail_q <= IB_IDX_W'(tail_sum);
            end
        end
    end

    // ------------------------------------------------
    // Push steering
    // ------------------------------------------------
    always_comb begin
        for (int e = 0; e < IB_DEPTH; e++) begin
            wr_data[e] = '0;
        end
        wr_en = '0;
        for (int i = 0; i < IS_NUM; i++) begin
            // Ready only below the free count, never on own valid
            s_ready_o[i] = (IB_CNT_W'(i) < free_cnt);
            push_idx[i]  = wrap_add(tail_q, i);
            if (push_en[i]) begin
                wr_en[push_idx[i]]   = 1'b1;
                wr_data[push_idx[i]] = s_data_i[i];
                // Squash of the same cycle also hits incoming work
                wr_data[push_idx[i]].live =
                    s_data_i[i].live & ~br_mis_i.valid[s_data_i[i].thread_idx];
            end
        end
    end

    // ------------------------------------------------
    // Pop lanes, lane k shows entry k past head
    // ------------------------------------------------
    always_comb begin
        for (int k = 0; k < ALU_NUM; k++) begin
            pop_idx[k]   = wrap_add(head_q, k);
            m_valid_o[k] = (IB_CNT_W'(k) < stored_cnt);
            m_data_o[k]  = entry_q[pop_idx[k]];
        end
    end

    // ------------------------------------------------
    // Entry storage
    // ------------------------------------------------
    always_ff @(posedge clk_i) begin
        for (int e = 0; e < IB_DEPTH; e++) begin
            if (exception_i) begin
                entry_q[e].live <= 1'b0;
            end else if (wr_en[e]) begin
                entry_q[e] <= wr_data[e];
            end else if (br_mis_i.valid[entry_q[e].thread_idx]) begin
                // Slot stays, only the live bit goes
                entry_q[e].live <= 1'b0;
            end
        end
    end

endmodule

//--- verilog/issue_buffer.sv
// ------------------------------------------------
// Integer issue path, queue feeding ALU_NUM lanes
// Push to result at least 2 cycles, longer under stalls
// ------------------------------------------------
`timescale 1ns/100ps

module issue_buffer import ib_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,
    // Push lanes
    input  logic     [IS_NUM-1:0]  s_valid_i,
    output logic     [IS_NUM-1:0]  s_ready_o,
    input  is_inst_t [IS_NUM-1:0]  s_data_i,
    // Squash and flush
    input  br_mis_t                br_mis_i,
    input  logic                   exception_i,
    // Result lanes
    output logic     [ALU_NUM-1:0] res_valid_o,
    input  logic     [ALU_NUM-1:0] res_ready_i,
    output alu_res_t [ALU_NUM-1:0] res_data_o
);

    // Queue to ALU lane handshake
    logic     [ALU_NUM-1:0] m_valid;
    logic     [ALU_NUM-1:0] m_ready;
    is_inst_t [ALU_NUM-1:0] m_data;

    // ------------------------------------------------
    // Issue queue
    // ------------------------------------------------
    ib_queue u_queue (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .s_valid_i   (s_valid_i),
        .s_ready_o   (s_ready_o),
        .s_data_i    (s_data_i),
        .m_valid_o   (m_valid),
        .m_ready_i   (m_ready),
        .m_data_o    (m_data),
        .br_mis_i    (br_mis_i),
        .exception_i (exception_i)
    );

    // ------------------------------------------------
    // ALU lanes, lane k takes pop lane k
    // ------------------------------------------------
    for (genvar k = 0; k < ALU_NUM; k++) begin : g_alu
        ib_alu_lane u_alu (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .inst_valid_i (m_valid[k]),
            .inst_ready_o (m_ready[k]),
            .inst_i       (m_data[k]),
            .br_mis_i     (br_mis_i),
            .exception_i  (exception_i),
            .res_valid_o  (res_valid_o[k]),
            .res_ready_i  (res_ready_i[k]),
            .res_o        (res_data_o[k])
        );
    end

endmodule
